// ==== csi2_tx_ctrl.f ====
design/csi2_tx_pkg.sv
design/csi2_tx_delay_timer.sv
design/csi2_tx_sequencer.sv
design/csi2_tx_header_regs.sv
design/csi2_tx_payload_gen.sv
design/csi2_tx_ctrl.sv
bench/csi2_tx_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= csi2_tx_ctrl_tb
FILELIST  ?= csi2_tx_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/csi2_tx_ctrl_tb.sv ====
`timescale 1ns/1ps

module csi2_tx_ctrl_tb import csi2_tx_pkg::*; ();

	localparam int NUM_LINES       = 4;
	localparam int PIXEL_WC        = 20;
	localparam int EXPOSURE_CYCLES = 12;
	localparam int EMB_PER_FRAME   = 2;
	localparam int FRAME_PKTS      = 2 + EMB_PER_FRAME + NUM_LINES; // FS, lines, FE
	localparam int HS_BURST        = 7; // HS hold delay plus one

	logic        byte_clk = 1'b0;
	logic        reset_n;
	logic        pll_lock;
	logic        tinit_done;
	logic        start_stream;
	logic        c2d_ready;
	logic        d_hs_rdy = 1'b0;
	logic        ld_pyld = 1'b0;
	bayer_pix_t  pixel = '0;
	logic        clk_hs_en;
	logic        d_hs_en;
	logic        sp_en;
	logic        lp_en;
	pkt_hdr_t    hdr;
	logic        byte_en;
	lane_bytes_t byte_data;

	// Core model state
	int rdy_wait = 0;
	int pyld_wait = 0;
	int seed = 32'h9552;

	// Monitor state
	pkt_hdr_t    hdr_log[$];
	logic [1:0]  en_log[$]; // {sp_en, lp_en} of each packet
	lane_bytes_t beats[$];
	bayer_pix_t  line_pix;
	data_type_t  cur_dt = 6'h3F;
	int          pix_line_idx = 0;
	int          activity = 0;
	int          mon_checks = 0;
	int          emb_err = 0;
	int          pix_err = 0;
	int          pkt_err = 0;
	int          hs_run = 0;
	int          emb_lines = 0;
	int          pix_lines = 0;

	int   main_checks = 0;
	int   test_err[1:5] = '{default: 0};
	logic timed_out = 1'b0;

	always #4 byte_clk = ~byte_clk;

	csi2_tx_ctrl #(
		.NUM_LINES       (NUM_LINES),
		.PIXEL_WC        (PIXEL_WC),
		.EXPOSURE_CYCLES (EXPOSURE_CYCLES)
	) dut_i (
		.ctrl_tx_byte_clk_i     (byte_clk),
		.ctrl_tx_reset_i        (reset_n),
		.ctrl_tx_pll_lock_i     (pll_lock),
		.ctrl_tx_tinit_done_i   (tinit_done),
		.ctrl_tx_start_stream_i (start_stream),
		.ctrl_tx_c2d_ready_i    (c2d_ready),
		.ctrl_tx_d_hs_rdy_i     (d_hs_rdy),
		.ctrl_tx_ld_pyld_i      (ld_pyld),
		.ctrl_tx_pixel_i        (pixel),
		.ctrl_tx_clk_hs_en_o    (clk_hs_en),
		.ctrl_tx_d_hs_en_o      (d_hs_en),
		.ctrl_tx_sp_en_o        (sp_en),
		.ctrl_tx_lp_en_o        (lp_en),
		.ctrl_tx_hdr_o          (hdr),
		.ctrl_tx_byte_data_en_o (byte_en),
		.ctrl_tx_byte_data_o    (byte_data)
	);

	function automatic bayer_pix_t random_bayer();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = $random(seed);
		r1 = $random(seed);
		return {r0[19:10], r0[9:0], r1[19:10], r1[9:0]};
	endfunction

	// Expected {lane1, lane0} for one beat of a line
	function automatic lane_bytes_t expected_bytes(input pkt_kind_t kind, input logic odd,
			input int beat, input bayer_pix_t pix);
		lane_bytes_t r;
		pixel_t      a;
		pixel_t      b;
		byte_t       low;
		a   = odd ? pix.green_blue : pix.red;
		b   = odd ? pix.blue : pix.green_red;
		low = {a[1:0], b[1:0], a[1:0], b[1:0]};
		if (kind == PKT_PIXEL) begin
			case (beat % 5)
				0, 1:    r = {b[9:2], a[9:2]};
				2:       r = {a[9:2], low};
				3:       r = {a[9:2], b[9:2]};
				default: r = {low, b[9:2]};
			endcase
		end else begin
			case (beat)
				0:       r = {8'h07, 8'h0A}; // Format byte on lane 0
				2:       r = {8'h07, 8'h55};
				4:       r = {8'h55, 8'h07};
				default: r = {8'h07, 8'h07};
			endcase
		end
		return r;
	endfunction

	function automatic pkt_hdr_t expected_header(input int k, input int frame_no);
		pkt_hdr_t h;
		h.vc = 2'd0;
		if (k == 0 || k == FRAME_PKTS - 1) begin
			h.dt = (k == 0) ? 6'h00 : 6'h01;
			h.wc = 16'(frame_no);
		end else if (k <= EMB_PER_FRAME) begin
			h.dt = 6'h12;
			h.wc = 16'd10;
		end else begin
			h.dt = 6'h2B;
			h.wc = 16'(PIXEL_WC);
		end
		return h;
	endfunction

	// Core model: HS ready lags the HS enable, payload load follows lp_en
	always @(posedge byte_clk) begin
		if (d_hs_en) begin
			d_hs_rdy <= 1'b0;
			rdy_wait <= 3;
		end else if (rdy_wait != 0) begin
			rdy_wait <= rdy_wait - 1;
			if (rdy_wait == 1) begin
				d_hs_rdy <= 1'b1;
			end
		end
		if (lp_en) begin
			ld_pyld   <= 1'b1;
			pyld_wait <= 2 + ({$random(seed)} % 5);
			pixel     <= random_bayer(); // New pixels for each line
		end else if (pyld_wait != 0) begin
			pyld_wait <= pyld_wait - 1;
			if (pyld_wait == 1) begin
				ld_pyld <= 1'b0;
			end
		end
	end

	task automatic check_line();
		logic        is_pix;
		logic        odd;
		int          exp_len;
		lane_bytes_t exp;
		is_pix  = (cur_dt == 6'h2B);
		odd     = pix_line_idx[0];
		exp_len = is_pix ? PIXEL_WC / 2 : 5;
		mon_checks++;
		assert ((is_pix || cur_dt == 6'h12) && beats.size() == exp_len) else begin
			$display("FAIL t=%0t: line after dt %h has %0d enabled cycles, expected %0d",
				$time, cur_dt, beats.size(), exp_len);
			if (is_pix) begin
				pix_err++;
			end else begin
				emb_err++;
			end
		end
		for (int i = 0; i < beats.size(); i++) begin
			exp = expected_bytes(is_pix ? PKT_PIXEL : PKT_EMBEDDED, odd, i, line_pix);
			mon_checks++;
			assert (beats[i] == exp) else begin
				$display("FAIL t=%0t: dt %h beat %0d bytes %h, expected %h",
					$time, cur_dt, i, beats[i], exp);
				if (is_pix) begin
					pix_err++;
				end else begin
					emb_err++;
				end
			end
		end
		if (is_pix) begin
			pix_lines++;
			pix_line_idx++;
		end else begin
			emb_lines++;
		end
	endtask

	// Monitor samples between edges
	always @(negedge byte_clk) begin
		if (reset_n) begin
			if (clk_hs_en || d_hs_en || sp_en || lp_en || byte_en) begin
				activity++;
			end
			assert (clk_hs_en == d_hs_en) else begin
				$display("FAIL t=%0t: clk_hs_en %b differs from d_hs_en %b",
					$time, clk_hs_en, d_hs_en);
				pkt_err++;
			end
			if (d_hs_en) begin
				hs_run++;
			end else if (hs_run != 0) begin
				mon_checks++;
				assert (hs_run == HS_BURST) else begin
					$display("FAIL t=%0t: HS enables high for %0d cycles, expected %0d",
						$time, hs_run, HS_BURST);
					pkt_err++;
				end
				hs_run = 0;
			end
			if (sp_en || lp_en) begin
				hdr_log.push_back(hdr);
				en_log.push_back({sp_en, lp_en});
				cur_dt = hdr.dt;
				if (hdr.dt == 6'h00) begin
					pix_line_idx = 0; // Each frame opens on an R/Gr line
				end
			end
			if (byte_en) begin
				if (beats.size() == 0) begin
					line_pix = pixel;
				end
				beats.push_back(byte_data);
			end else if (beats.size() != 0) begin
				check_line();
				beats.delete();
			end
		end
	end

	task automatic check_idle(input string when_txt);
		@(negedge byte_clk);
		main_checks++;
		assert (!clk_hs_en && !d_hs_en && !sp_en && !lp_en && !byte_en
			&& byte_data == '0 && hdr == '0) else begin
			$display("FAIL t=%0t: outputs not idle %s", $time, when_txt);
			test_err[1]++;
		end
	endtask

	task automatic wait_headers(input int count, input int limit, input string what,
			input int test_no);
		int n;
		n = 0;
		while (hdr_log.size() < count && n < limit) begin
			@(posedge byte_clk);
			n++;
		end
		if (hdr_log.size() < count) begin
			$display("Timeout: no %s after %0d clock cycles", what, limit);
			test_err[test_no]++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_all_headers();
		pkt_hdr_t   got;
		pkt_hdr_t   exp;
		int         k;
		int         frame_no [4];
		logic [1:0] exp_en;
		frame_no = '{1, 2, 3, 1}; // Counter restarts after the stream stop
		for (int i = 0; i < hdr_log.size() && i < 4 * FRAME_PKTS; i++) begin
			got = hdr_log[i];
			k   = i % FRAME_PKTS;
			exp = expected_header(k, frame_no[i / FRAME_PKTS]);
			main_checks++;
			assert (got.vc == exp.vc && got.dt == exp.dt
				&& (k == 0 || k == FRAME_PKTS - 1 || got.wc == exp.wc)) else begin
				$display("FAIL t=%0t: header %0d is vc %0d dt %h wc %0d, expected vc %0d dt %h wc %0d",
					$time, i, got.vc, got.dt, got.wc, exp.vc, exp.dt, exp.wc);
				test_err[2]++;
			end
			exp_en = (k == 0 || k == FRAME_PKTS - 1) ? 2'b10 : 2'b01; // Short or long packet
			main_checks++;
			assert (en_log[i] == exp_en) else begin
				$display("FAIL t=%0t: header %0d sent with sp_en,lp_en %b, expected %b",
					$time, i, en_log[i], exp_en);
				test_err[2]++;
			end
			if (k == 0 || k == FRAME_PKTS - 1) begin
				main_checks++;
				assert (got.wc == exp.wc) else begin
					$display("FAIL t=%0t: header %0d frame number %0d, expected %0d",
						$time, i, got.wc, exp.wc);
					test_err[5]++;
				end
			end
		end
	endtask

	task automatic report_test(input int no, input string name, input int errs);
		$display("Test %0d %-22s %s, %0d errors", no, name, (errs == 0) ? "ok" : "FAILED", errs);
	endtask

	initial begin
		int total;
		reset_n      = 1'b0;
		pll_lock     = 1'b0;
		tinit_done   = 1'b0;
		start_stream = 1'b0;
		c2d_ready    = 1'b1; // Core always ready for the next packet
		repeat (5) @(posedge byte_clk);
		check_idle("during reset");
		repeat (5) @(posedge byte_clk);
		reset_n <= 1'b1;

		// PHY bring-up without the stream level
		repeat (20) @(posedge byte_clk);
		pll_lock <= 1'b1;
		repeat (10) @(posedge byte_clk);
		tinit_done <= 1'b1;
		repeat (20) @(posedge byte_clk);
		check_idle("before stream start");
		main_checks++;
		assert (activity == 0 && hdr_log.size() == 0) else begin
			$display("FAIL t=%0t: PHY activity before stream start", $time);
			test_err[1]++;
		end
		report_test(1, "reset and startup", test_err[1]);

		@(posedge byte_clk);
		start_stream <= 1'b1;
		wait_headers(2 * FRAME_PKTS + 1, 2000, "FS of frame 3", 2);
		if (!timed_out) begin
			start_stream <= 1'b0; // Frame 3 still completes
			wait_headers(3 * FRAME_PKTS, 2000, "FE of frame 3", 5);
		end
		if (!timed_out) begin
			repeat (100) @(posedge byte_clk);
			main_checks++;
			assert (hdr_log.size() == 3 * FRAME_PKTS) else begin
				$display("FAIL t=%0t: packets sent after the stream was stopped", $time);
				test_err[5]++;
			end
			start_stream <= 1'b1;
			wait_headers(4 * FRAME_PKTS, 2000, "FE after stream restart", 5);
		end

		check_all_headers();
		main_checks += 2;
		assert (emb_lines == 4 * EMB_PER_FRAME) else begin
			$display("FAIL t=%0t: %0d embedded lines seen, expected %0d",
				$time, emb_lines, 4 * EMB_PER_FRAME);
			test_err[3]++;
		end
		assert (pix_lines == 4 * NUM_LINES) else begin
			$display("FAIL t=%0t: %0d pixel lines seen, expected %0d",
				$time, pix_lines, 4 * NUM_LINES);
			test_err[4]++;
		end
		report_test(2, "header sequence", test_err[2] + pkt_err);
		report_test(3, "embedded lines", test_err[3] + emb_err);
		report_test(4, "pixel lines", test_err[4] + pix_err);
		report_test(5, "frame count and restart", test_err[5]);

		total = test_err[1] + test_err[2] + test_err[3] + test_err[4] + test_err[5]
			+ emb_err + pix_err + pkt_err;
		$display("Checks: %0d, errors: %0d", main_checks + mon_checks, total);
		if (total == 0 && !timed_out) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== design/csi2_tx_ctrl.sv ====
`timescale 1ns/1ps

module csi2_tx_ctrl import csi2_tx_pkg::*; #(
	parameter int NUM_LINES       = 2464,
	parameter int PIXEL_WC        = 4080,
	parameter int EXPOSURE_CYCLES = 3200
) (
	input  logic        ctrl_tx_byte_clk_i,
	input  logic        ctrl_tx_reset_i,
	input  logic        ctrl_tx_pll_lock_i,
	input  logic        ctrl_tx_tinit_done_i,
	input  logic        ctrl_tx_start_stream_i,
	input  logic        ctrl_tx_c2d_ready_i,
	input  logic        ctrl_tx_d_hs_rdy_i,
	input  logic        ctrl_tx_ld_pyld_i,
	input  bayer_pix_t  ctrl_tx_pixel_i,
	output logic        ctrl_tx_clk_hs_en_o,
	output logic        ctrl_tx_d_hs_en_o,
	output logic        ctrl_tx_sp_en_o,
	output logic        ctrl_tx_lp_en_o,
	output pkt_hdr_t    ctrl_tx_hdr_o,
	output logic        ctrl_tx_byte_data_en_o,
	output lane_bytes_t ctrl_tx_byte_data_o
);

	logic      hdr_load;
	pkt_kind_t hdr_kind;
	logic      frame_advance;
	logic      frame_clear;
	logic      line_start;
	line_req_t line_req;
	logic      line_done;

	csi2_tx_sequencer #(
		.NUM_LINES       (NUM_LINES),
		.EXPOSURE_CYCLES (EXPOSURE_CYCLES)
	) sequencer_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.pll_lock_i         (ctrl_tx_pll_lock_i),
		.tinit_done_i       (ctrl_tx_tinit_done_i),
		.start_stream_i     (ctrl_tx_start_stream_i),
		.c2d_ready_i        (ctrl_tx_c2d_ready_i),
		.d_hs_rdy_i         (ctrl_tx_d_hs_rdy_i),
		.ld_pyld_i          (ctrl_tx_ld_pyld_i),
		.line_done_i        (line_done),
		.clk_hs_en_o        (ctrl_tx_clk_hs_en_o),
		.d_hs_en_o          (ctrl_tx_d_hs_en_o),
		.sp_en_o            (ctrl_tx_sp_en_o),
		.lp_en_o            (ctrl_tx_lp_en_o),
		.hdr_load_o         (hdr_load),
		.hdr_kind_o         (hdr_kind),
		.frame_advance_o    (frame_advance),
		.frame_clear_o      (frame_clear),
		.line_start_o       (line_start),
		.line_req_o         (line_req)
	);

	csi2_tx_header_regs #(
		.PIXEL_WC (PIXEL_WC)
	) header_regs_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.hdr_load_i         (hdr_load),
		.hdr_kind_i         (hdr_kind),
		.frame_advance_i    (frame_advance),
		.frame_clear_i      (frame_clear),
		.hdr_o              (ctrl_tx_hdr_o)
	);

	csi2_tx_payload_gen #(
		.PIXEL_WC (PIXEL_WC)
	) payload_gen_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.line_start_i       (line_start),
		.line_req_i         (line_req),
		.pixel_i            (ctrl_tx_pixel_i),
		.byte_data_en_o     (ctrl_tx_byte_data_en_o),
		.byte_data_o        (ctrl_tx_byte_data_o),
		.line_done_o        (line_done)
	);

endmodule

// ==== design/csi2_tx_payload_gen.sv ====
`timescale 1ns/1ps

module csi2_tx_payload_gen import csi2_tx_pkg::*; #(
	parameter int PIXEL_WC = 4080
) (
	input  logic        ctrl_tx_byte_clk_i,
	input  logic        ctrl_tx_reset_i,
	input  logic        line_start_i,
	input  line_req_t   line_req_i,
	input  bayer_pix_t  pixel_i,
	output logic        byte_data_en_o,
	output lane_bytes_t byte_data_o,
	output logic        line_done_o
);

	// Two lanes, so one beat per byte pair
	localparam word_count_t EMB_LAST = word_count_t'(EMB_WC / 2 - 1);
	localparam word_count_t PIX_LAST = word_count_t'(PIXEL_WC / 2 - 1);

	typedef enum logic [2:0] {
		GEAR_0,
		GEAR_1,
		GEAR_2,
		GEAR_3,
		GEAR_4
	} gear_t;

	gear_t       gear_q;
	gear_t       gear_d;
	word_count_t beat_q;
	word_count_t beat_d;
	word_count_t last_beat;
	logic        advance;
	pixel_t      pix_a;
	pixel_t      pix_b;
	byte_t       pix_lsb;
	lane_bytes_t bytes_d;

	if (PIXEL_WC % 10 != 0) begin : g_wc_check
		$error("PIXEL_WC must be a multiple of 10");
	end

	assign pix_a   = line_req_i.odd_line ? pixel_i.green_blue : pixel_i.red;
	assign pix_b   = line_req_i.odd_line ? pixel_i.blue : pixel_i.green_red;
	assign pix_lsb = {pix_a[1:0], pix_b[1:0], pix_a[1:0], pix_b[1:0]}; // RAW10 low bits

	assign last_beat = line_req_i.is_pixel ? PIX_LAST : EMB_LAST;
	assign advance   = line_start_i || (byte_data_en_o && beat_q != last_beat);

	always_comb begin
		if (line_start_i) begin
			beat_d = '0;
			gear_d = GEAR_0;
		end else begin
			beat_d = beat_q + 1'b1;
			unique case (gear_q)
				GEAR_0:  gear_d = GEAR_1;
				GEAR_1:  gear_d = GEAR_2;
				GEAR_2:  gear_d = GEAR_3;
				GEAR_3:  gear_d = GEAR_4;
				default: gear_d = GEAR_0;
			endcase
		end
	end

	// Byte pair for the beat being loaded
	always_comb begin
		if (line_req_i.is_pixel) begin
			unique case (gear_d)
				GEAR_0, GEAR_1: begin
					bytes_d.lane0 = pix_a[9:2];
					bytes_d.lane1 = pix_b[9:2];
				end
				GEAR_2: begin
					bytes_d.lane0 = pix_lsb;
					bytes_d.lane1 = pix_a[9:2];
				end
				GEAR_3: begin
					bytes_d.lane0 = pix_b[9:2];
					bytes_d.lane1 = pix_a[9:2];
				end
				default: begin
					bytes_d.lane0 = pix_b[9:2];
					bytes_d.lane1 = pix_lsb;
				end
			endcase
		end else begin
			bytes_d.lane1 = EMB_END_BYTE;
			unique case (beat_d[2:0])
				3'd0:    bytes_d.lane0 = EMB_FORMAT_BYTE;
				3'd2:    bytes_d.lane0 = EMB_PAD_BYTE;
				3'd4: begin
					bytes_d.lane0 = EMB_END_BYTE;
					bytes_d.lane1 = EMB_PAD_BYTE; // Pad to the RAW10 group size
				end
				default: bytes_d.lane0 = EMB_END_BYTE;
			endcase
		end
	end

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			byte_data_en_o <= 1'b0;
			byte_data_o    <= '0;
			line_done_o    <= 1'b0;
			beat_q         <= '0;
			gear_q         <= GEAR_0;
		end else begin
			line_done_o <= 1'b0;
			if (advance) begin
				byte_data_en_o <= 1'b1;
				byte_data_o    <= bytes_d;
				beat_q         <= beat_d;
				gear_q         <= gear_d;
			end else if (byte_data_en_o) begin
				byte_data_en_o <= 1'b0; // Last beat has gone out
				byte_data_o    <= '0;
				line_done_o    <= 1'b1;
			end
		end
	end

	a_start_when_idle: assert property (@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		line_start_i |-> !byte_data_en_o && !line_done_o)
		else $error("line_start while a line is still being sent");

endmodule

// ==== design/csi2_tx_header_regs.sv ====
`timescale 1ns/1ps

module csi2_tx_header_regs import csi2_tx_pkg::*; #(
	parameter int PIXEL_WC = 4080
) (
	input  logic      ctrl_tx_byte_clk_i,
	input  logic      ctrl_tx_reset_i,
	input  logic      hdr_load_i,
	input  pkt_kind_t hdr_kind_i,
	input  logic      frame_advance_i,
	input  logic      frame_clear_i,
	output pkt_hdr_t  hdr_o
);

	word_count_t frame_cnt_q;

	// Frame number runs 1 to FRAME_CNT_MAX, zero is never sent
	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			frame_cnt_q <= word_count_t'(1);
		end else if (frame_clear_i) begin
			frame_cnt_q <= word_count_t'(1);
		end else if (frame_advance_i) begin
			if (frame_cnt_q == FRAME_CNT_MAX) begin
				frame_cnt_q <= word_count_t'(1);
			end else begin
				frame_cnt_q <= frame_cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			hdr_o <= '0;
		end else if (hdr_load_i) begin
			hdr_o.vc <= VIRTUAL_CHANNEL;
			unique case (hdr_kind_i)
				PKT_FS: begin
					hdr_o.dt <= DT_FS;
					hdr_o.wc <= frame_cnt_q; // Short packets carry the frame number
				end
				PKT_FE: begin
					hdr_o.dt <= DT_FE;
					hdr_o.wc <= frame_cnt_q;
				end
				PKT_EMBEDDED: begin
					hdr_o.dt <= DT_EMBEDDED;
					hdr_o.wc <= EMB_WC;
				end
				default: begin
					hdr_o.dt <= DT_RAW10;
					hdr_o.wc <= word_count_t'(PIXEL_WC);
				end
			endcase
		end
	end

endmodule

// ==== design/csi2_tx_sequencer.sv ====
`timescale 1ns/1ps

module csi2_tx_sequencer import csi2_tx_pkg::*; #(
	parameter int NUM_LINES       = 2464,
	parameter int EXPOSURE_CYCLES = 3200
) (
	input  logic      ctrl_tx_byte_clk_i,
	input  logic      ctrl_tx_reset_i,
	input  logic      pll_lock_i,
	input  logic      tinit_done_i,
	input  logic      start_stream_i,
	input  logic      c2d_ready_i,
	input  logic      d_hs_rdy_i,
	input  logic      ld_pyld_i,
	input  logic      line_done_i,
	output logic      clk_hs_en_o,
	output logic      d_hs_en_o,
	output logic      sp_en_o,
	output logic      lp_en_o,
	output logic      hdr_load_o,
	output pkt_kind_t hdr_kind_o,
	output logic      frame_advance_o,
	output logic      frame_clear_o,
	output logic      line_start_o,
	output line_req_t line_req_o
);

	typedef enum logic [3:0] {
		S_IDLE,       // Wait for PLL lock
		S_WAIT_INIT,  // Wait for D-PHY init
		S_WAIT_START,
		S_SETTLE,
		S_EXPOSE,
		S_C2D,        // Packet start, core ready
		S_HS,
		S_DHS,
		S_PKT_EN,
		S_PYLD,
		S_PYLD_DLY,
		S_LINE,
		S_FRAME       // Frame boundary
	} state_t;

	state_t      state_q;
	state_t      state_d;
	pkt_kind_t   kind_q;
	line_count_t emb_left_q;
	line_count_t pix_left_q;
	logic        odd_q;
	logic        is_short;
	logic        settle_done;
	logic        hs_done;
	logic        pkt_en_done;
	logic        expose_done;

	assign is_short = (kind_q == PKT_FS) || (kind_q == PKT_FE);

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			S_IDLE:       if (pll_lock_i) state_d = S_WAIT_INIT;
			S_WAIT_INIT:  if (tinit_done_i) state_d = S_WAIT_START;
			S_WAIT_START: if (start_stream_i) state_d = S_SETTLE;
			S_SETTLE:     if (settle_done) state_d = S_C2D;
			S_EXPOSE:     if (expose_done) state_d = S_HS; // c2d_ready already seen
			S_C2D:        if (c2d_ready_i) state_d = S_HS;
			S_HS:         if (hs_done) state_d = S_DHS;
			S_DHS:        if (d_hs_rdy_i) state_d = S_PKT_EN;
			S_PKT_EN: begin
				if (pkt_en_done) begin
					if (kind_q == PKT_FE) begin
						state_d = S_FRAME;
					end else if (kind_q == PKT_FS) begin
						state_d = S_C2D;
					end else begin
						state_d = S_PYLD;
					end
				end
			end
			S_PYLD:       if (!ld_pyld_i) state_d = S_PYLD_DLY;
			S_PYLD_DLY:   state_d = S_LINE;
			S_LINE:       if (line_done_i) state_d = S_C2D;
			S_FRAME: begin
				if (!start_stream_i) begin
					state_d = S_IDLE;
				end else if (c2d_ready_i) begin
					state_d = S_EXPOSE;
				end
			end
			default:      state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			state_q    <= S_IDLE;
			kind_q     <= PKT_FS;
			emb_left_q <= '0;
			pix_left_q <= '0;
			odd_q      <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == S_IDLE || frame_advance_o) begin
				kind_q <= PKT_FS;
			end
			// FS sent, arm the line loop for this frame
			if (sp_en_o && kind_q == PKT_FS) begin
				kind_q     <= PKT_EMBEDDED;
				emb_left_q <= EMB_LINES;
				pix_left_q <= line_count_t'(NUM_LINES);
				odd_q      <= 1'b0;
			end
			if (state_q == S_LINE && line_done_i) begin
				if (kind_q == PKT_EMBEDDED) begin
					emb_left_q <= emb_left_q - 1'b1;
					if (emb_left_q == line_count_t'(1)) kind_q <= PKT_PIXEL;
				end else begin
					pix_left_q <= pix_left_q - 1'b1;
					odd_q      <= !odd_q; // Alternate R/Gr and Gb/B lines
					if (pix_left_q == line_count_t'(1)) kind_q <= PKT_FE;
				end
			end
		end
	end

	// Timers start with the next state so their done lines up with the exit edge
	csi2_tx_delay_timer #(.CYCLES(TINIT_WAIT_CYCLES)) tinit_timer_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.start_i            (state_d == S_SETTLE),
		.done_o             (settle_done)
	);

	csi2_tx_delay_timer #(.CYCLES(HS_HOLD_CYCLES)) hs_timer_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.start_i            (state_d == S_HS),
		.done_o             (hs_done)
	);

	csi2_tx_delay_timer #(.CYCLES(PKT_EN_DELAY_CYCLES)) pkt_en_timer_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.start_i            (state_d == S_PKT_EN),
		.done_o             (pkt_en_done)
	);

	csi2_tx_delay_timer #(.CYCLES(EXPOSURE_CYCLES)) exposure_timer_i (
		.ctrl_tx_byte_clk_i (ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i    (ctrl_tx_reset_i),
		.start_i            (state_d == S_EXPOSE),
		.done_o             (expose_done)
	);

	assign clk_hs_en_o     = (state_q == S_HS);
	assign d_hs_en_o       = (state_q == S_HS);
	assign hdr_load_o      = (state_q == S_DHS) && d_hs_rdy_i;
	assign sp_en_o         = (state_q == S_PKT_EN) && pkt_en_done && is_short;
	assign lp_en_o         = (state_q == S_PKT_EN) && pkt_en_done && !is_short;
	assign hdr_kind_o      = kind_q;
	assign frame_advance_o = (state_q == S_FRAME) && start_stream_i && c2d_ready_i;
	assign frame_clear_o   = (state_q == S_FRAME) && !start_stream_i;
	assign line_start_o    = (state_q == S_PYLD_DLY); // One clock after ld_pyld falls

	assign line_req_o.is_pixel = (kind_q == PKT_PIXEL);
	assign line_req_o.odd_line = odd_q;

	// Exactly one packet enable, the enable delay plus one after the header load
	a_pkt_en_pulse: assert property (@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		hdr_load_o |-> ##(PKT_EN_DELAY_CYCLES + 1) (sp_en_o ^ lp_en_o))
		else $error("sp_en and lp_en not a single enable after the header load");

	// Byte data runs between line_start and line_done
	a_no_hs_in_line: assert property (@(posedge ctrl_tx_byte_clk_i) disable iff (!ctrl_tx_reset_i)
		line_start_o |=> !(clk_hs_en_o || d_hs_en_o) throughout line_done_i[->1])
		else $error("HS enable raised while byte data is enabled");

endmodule

// ==== design/csi2_tx_delay_timer.sv ====
`timescale 1ns/1ps

module csi2_tx_delay_timer #(
	parameter int CYCLES = 4
) (
	input  logic ctrl_tx_byte_clk_i,
	input  logic ctrl_tx_reset_i,
	input  logic start_i,
	output logic done_o
);

	localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES + 1) : 1;

	logic [CNT_W-1:0] cnt_q;

	// Count runs only while start is held, done follows one clock after zero
	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			cnt_q  <= CNT_W'(CYCLES);
			done_o <= 1'b0;
		end else if (!start_i) begin
			cnt_q  <= CNT_W'(CYCLES); // Reload for the next use
			done_o <= 1'b0;
		end else begin
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			done_o <= (cnt_q == '0);
		end
	end

endmodule

// ==== design/csi2_tx_pkg.sv ====
package csi2_tx_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [9:0]  pixel_t;
	typedef logic [5:0]  data_type_t;
	typedef logic [15:0] word_count_t; // Also carries the frame number
	typedef logic [11:0] line_count_t;

	typedef struct packed {
		byte_t lane1;
		byte_t lane0;
	} lane_bytes_t;

	typedef struct packed {
		pixel_t red;
		pixel_t green_red;
		pixel_t green_blue;
		pixel_t blue;
	} bayer_pix_t;

	typedef struct packed {
		logic [1:0]  vc;
		data_type_t  dt;
		word_count_t wc;
	} pkt_hdr_t;

	typedef enum logic [1:0] {
		PKT_FS,
		PKT_FE,
		PKT_EMBEDDED,
		PKT_PIXEL
	} pkt_kind_t;

	typedef struct packed {
		logic is_pixel;
		logic odd_line; // Gb/B line of the Bayer pair
	} line_req_t;

	// CSI-2 data type codes
	localparam data_type_t DT_FS       = 6'h00;
	localparam data_type_t DT_FE       = 6'h01;
	localparam data_type_t DT_EMBEDDED = 6'h12;
	localparam data_type_t DT_RAW10    = 6'h2B;

	localparam logic [1:0]  VIRTUAL_CHANNEL = 2'd0;
	localparam word_count_t EMB_WC          = 16'd10; // Bytes per embedded line
	localparam line_count_t EMB_LINES       = 12'd2;
	localparam word_count_t FRAME_CNT_MAX   = 16'd65534;

	// Fixed PHY handshake delays in byte clocks
	localparam int TINIT_WAIT_CYCLES   = 4;
	localparam int HS_HOLD_CYCLES      = 6;
	localparam int PKT_EN_DELAY_CYCLES = 7;

	localparam byte_t EMB_FORMAT_BYTE = 8'h0A;
	localparam byte_t EMB_END_BYTE    = 8'h07;
	localparam byte_t EMB_PAD_BYTE    = 8'h55;

endpackage
